// File: Makefile
# Verilator build and run for the NoC test system

VERILATOR ?= verilator
TOP       ?= noc_test_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/noc_defines.svh
// NoC test system sizes
// Widths and depths shared by the RTL and the testbench

`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Bit 7 picks the target node, bit 6 the owner node, bits 5:0 the word
`define NOC_ADDR_W 8

// One data word, also the LFSR width
`define NOC_DATA_W 16

// Words per responder, indexed by address bits 6:0
`define NOC_MEM_DEPTH 128

// Transaction count and error count width
`define NOC_CNT_W 8

// Galois LFSR feedback taps
`define NOC_LFSR_POLY 16'hB400

`endif

// File: source/mem_responder.sv
// Memory responder
// Word memory behind a four-phase slave port with one-cycle turns

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module mem_responder (
  input  logic                   rst_ni,      // Clock
  input  logic                   rst_n_i,     // Async reset, active low
  input  logic                   req_i,
  input  noc_pkg::noc_op_e       op_i,
  input  logic [`NOC_ADDR_W-1:0] addr_i,
  input  logic [`NOC_DATA_W-1:0] wdata_i,
  output logic                   ack_o,
  output logic [`NOC_DATA_W-1:0] rdata_o
);

  import noc_pkg::*;

  localparam int IDX_W = $clog2(`NOC_MEM_DEPTH);

  logic [`NOC_DATA_W-1:0] mem [`NOC_MEM_DEPTH];
  logic [IDX_W-1:0]       idx;
  logic                   accept;

  // Owner bit and word index, the target bit is already decoded
  assign idx    = addr_i[IDX_W-1:0];
  assign accept = req_i && !ack_o;

  always_ff @(posedge rst_ni or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else if (accept) begin
      ack_o <= 1'b1;
    end else if (!req_i) begin
      ack_o <= 1'b0;
    end
  end

  // rdata stays valid until the next read is accepted
  always_ff @(posedge rst_ni) begin
    if (accept) begin
      if (op_i == OP_WRITE) begin
        mem[idx] <= wdata_i;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/noc_pkg.sv
// NoC test system types
// Opcode and FSM state encodings used across the design

`default_nettype none

package noc_pkg;

  // Request opcode on the four-phase channel
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } noc_op_e;

  // Traffic generator FSM
  typedef enum logic [2:0] {
    GEN_IDLE,
    GEN_REQ,
    GEN_WAIT_ACK_LOW,
    GEN_NEXT,
    GEN_DONE
  } gen_state_e;

  // Per-slave router port FSM
  typedef enum logic [1:0] {
    RTR_IDLE,
    RTR_BUSY,
    RTR_RELEASE
  } rtr_state_e;

endpackage

`default_nettype wire

// File: source/noc_test_top.sv
// NoC test system top level
// Two test nodes joined by the request router, plus a transaction
// monitor that reports each responder ack rise

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module noc_test_top (
  input  logic                   rst_ni,      // Clock
  input  logic                   rst_n_i,     // Async reset, active low
  input  logic                   start_i,
  input  logic [`NOC_DATA_W-1:0] seed0_i,
  input  logic [`NOC_DATA_W-1:0] seed1_i,
  input  logic [`NOC_CNT_W-1:0]  num_txn_i,
  output logic [1:0]             done_o,
  output logic [`NOC_CNT_W-1:0]  err_count0_o,
  output logic [`NOC_CNT_W-1:0]  err_count1_o,
  output logic                   mon_valid_o,
  output logic                   mon_node_o,
  output noc_pkg::noc_op_e       mon_op_o,
  output logic [`NOC_ADDR_W-1:0] mon_addr_o,
  output logic [`NOC_DATA_W-1:0] mon_data_o
);

  import noc_pkg::*;

  // Index is the node number on both sides
  logic [1:0]             m_req;
  noc_op_e                m_op [2];
  logic [`NOC_ADDR_W-1:0] m_addr [2];
  logic [`NOC_DATA_W-1:0] m_wdata [2];
  logic [1:0]             m_ack;
  logic [`NOC_DATA_W-1:0] m_rdata [2];
  logic [1:0]             s_req;
  noc_op_e                s_op [2];
  logic [`NOC_ADDR_W-1:0] s_addr [2];
  logic [`NOC_DATA_W-1:0] s_wdata [2];
  logic [1:0]             s_ack;
  logic [`NOC_DATA_W-1:0] s_rdata [2];

  logic [1:0]             ack_d;
  logic [1:0]             pend_q;
  logic [1:0]             pend_n;
  logic                   sel;

  test_node u_node0 (
    .rst_ni (rst_ni), .rst_n_i (rst_n_i), .start_i (start_i),
    .seed_i (seed0_i), .num_txn_i (num_txn_i), .node_id_i (1'b0),
    .m_req_o (m_req[0]), .m_op_o (m_op[0]), .m_addr_o (m_addr[0]),
    .m_wdata_o (m_wdata[0]), .m_ack_i (m_ack[0]), .m_rdata_i (m_rdata[0]),
    .s_req_i (s_req[0]), .s_op_i (s_op[0]), .s_addr_i (s_addr[0]),
    .s_wdata_i (s_wdata[0]), .s_ack_o (s_ack[0]), .s_rdata_o (s_rdata[0]),
    .done_o (done_o[0]), .err_count_o (err_count0_o)
  );

  test_node u_node1 (
    .rst_ni (rst_ni), .rst_n_i (rst_n_i), .start_i (start_i),
    .seed_i (seed1_i), .num_txn_i (num_txn_i), .node_id_i (1'b1),
    .m_req_o (m_req[1]), .m_op_o (m_op[1]), .m_addr_o (m_addr[1]),
    .m_wdata_o (m_wdata[1]), .m_ack_i (m_ack[1]), .m_rdata_i (m_rdata[1]),
    .s_req_i (s_req[1]), .s_op_i (s_op[1]), .s_addr_i (s_addr[1]),
    .s_wdata_i (s_wdata[1]), .s_ack_o (s_ack[1]), .s_rdata_o (s_rdata[1]),
    .done_o (done_o[1]), .err_count_o (err_count1_o)
  );

  req_router u_router (
    .rst_ni (rst_ni), .rst_n_i (rst_n_i),
    .m0_req_i (m_req[0]), .m0_op_i (m_op[0]), .m0_addr_i (m_addr[0]),
    .m0_wdata_i (m_wdata[0]), .m0_ack_o (m_ack[0]), .m0_rdata_o (m_rdata[0]),
    .m1_req_i (m_req[1]), .m1_op_i (m_op[1]), .m1_addr_i (m_addr[1]),
    .m1_wdata_i (m_wdata[1]), .m1_ack_o (m_ack[1]), .m1_rdata_o (m_rdata[1]),
    .s0_req_o (s_req[0]), .s0_op_o (s_op[0]), .s0_addr_o (s_addr[0]),
    .s0_wdata_o (s_wdata[0]), .s0_ack_i (s_ack[0]), .s0_rdata_i (s_rdata[0]),
    .s1_req_o (s_req[1]), .s1_op_o (s_op[1]), .s1_addr_o (s_addr[1]),
    .s1_wdata_o (s_wdata[1]), .s1_ack_i (s_ack[1]), .s1_rdata_i (s_rdata[1])
  );

  // Ack rises that are not yet reported, node 0 first.
  // A coincident node 1 rise goes out one cycle later
  assign pend_n = pend_q | (s_ack & ~ack_d);
  assign sel    = ~pend_n[0];

  always_ff @(posedge rst_ni or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_d       <= '0;
      pend_q      <= '0;
      mon_valid_o <= 1'b0;
    end else begin
      ack_d       <= s_ack;
      pend_q      <= pend_n & ~(2'b01 << sel);
      mon_valid_o <= |pend_n;
    end
  end

  // Responder fields and rdata hold while its ack is high
  always_ff @(posedge rst_ni) begin
    if (|pend_n) begin
      mon_node_o <= sel;
      mon_op_o   <= s_op[sel];
      mon_addr_o <= s_addr[sel];
      if (s_op[sel] == OP_WRITE) begin
        mon_data_o <= s_wdata[sel];
      end else begin
        mon_data_o <= s_rdata[sel];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/req_router.sv
// Request router
// Connects two four-phase masters to two slaves. Address bit 7 picks
// the slave, each slave port arbitrates round-robin and holds its grant
// until the slave's ack falls

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module req_router (
  input  logic                   rst_ni,      // Clock
  input  logic                   rst_n_i,     // Async reset, active low
  input  logic                   m0_req_i,
  input  noc_pkg::noc_op_e       m0_op_i,
  input  logic [`NOC_ADDR_W-1:0] m0_addr_i,
  input  logic [`NOC_DATA_W-1:0] m0_wdata_i,
  output logic                   m0_ack_o,
  output logic [`NOC_DATA_W-1:0] m0_rdata_o,
  input  logic                   m1_req_i,
  input  noc_pkg::noc_op_e       m1_op_i,
  input  logic [`NOC_ADDR_W-1:0] m1_addr_i,
  input  logic [`NOC_DATA_W-1:0] m1_wdata_i,
  output logic                   m1_ack_o,
  output logic [`NOC_DATA_W-1:0] m1_rdata_o,
  output logic                   s0_req_o,
  output noc_pkg::noc_op_e       s0_op_o,
  output logic [`NOC_ADDR_W-1:0] s0_addr_o,
  output logic [`NOC_DATA_W-1:0] s0_wdata_o,
  input  logic                   s0_ack_i,
  input  logic [`NOC_DATA_W-1:0] s0_rdata_i,
  output logic                   s1_req_o,
  output noc_pkg::noc_op_e       s1_op_o,
  output logic [`NOC_ADDR_W-1:0] s1_addr_o,
  output logic [`NOC_DATA_W-1:0] s1_wdata_o,
  input  logic                   s1_ack_i,
  input  logic [`NOC_DATA_W-1:0] s1_rdata_i
);

  import noc_pkg::*;

  logic [1:0]             m_req;
  noc_op_e                m_op [2];
  logic [`NOC_ADDR_W-1:0] m_addr [2];
  logic [`NOC_DATA_W-1:0] m_wdata [2];
  logic [1:0]             s_ack;
  logic [`NOC_DATA_W-1:0] s_rdata [2];

  // Per slave port state, indexed by slave
  rtr_state_e             state_q [2];
  logic [1:0]             gnt_q;
  logic [1:0]             rr_q;
  logic [1:0]             req_q;
  logic [1:0]             ack_q;
  noc_op_e                op_q [2];
  logic [`NOC_ADDR_W-1:0] addr_q [2];
  logic [`NOC_DATA_W-1:0] wdata_q [2];
  logic [`NOC_DATA_W-1:0] rdata_q [2];

  logic [1:0]             want [2];
  logic [1:0]             win;

  assign m_req      = {m1_req_i, m0_req_i};
  assign m_op[0]    = m0_op_i;
  assign m_op[1]    = m1_op_i;
  assign m_addr[0]  = m0_addr_i;
  assign m_addr[1]  = m1_addr_i;
  assign m_wdata[0] = m0_wdata_i;
  assign m_wdata[1] = m1_wdata_i;
  assign s_ack      = {s1_ack_i, s0_ack_i};
  assign s_rdata[0] = s0_rdata_i;
  assign s_rdata[1] = s1_rdata_i;

  // Decode and pick a winner, the pointer master goes first
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      for (int m = 0; m < 2; m++) begin
        want[s][m] = m_req[m] && (m_addr[m][`NOC_ADDR_W-1] == s[0]);
      end
      if (want[s][rr_q[s]]) begin
        win[s] = rr_q[s];
      end else begin
        win[s] = ~rr_q[s];
      end
    end
  end

  always_ff @(posedge rst_ni or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < 2; s++) begin
        state_q[s] <= RTR_IDLE;
      end
      gnt_q <= '0;
      rr_q  <= '0;
      req_q <= '0;
      ack_q <= '0;
    end else begin
      ack_q <= s_ack;
      for (int s = 0; s < 2; s++) begin
        case (state_q[s])
          RTR_IDLE: begin
            if (|want[s]) begin
              gnt_q[s]   <= win[s];
              rr_q[s]    <= ~win[s];
              req_q[s]   <= 1'b1;
              state_q[s] <= RTR_BUSY;
            end
          end
          RTR_BUSY: begin
            // Master saw ack and dropped req
            if (ack_q[s] && !m_req[gnt_q[s]]) begin
              req_q[s]   <= 1'b0;
              state_q[s] <= RTR_RELEASE;
            end
          end
          RTR_RELEASE: begin
            if (!s_ack[s]) begin
              state_q[s] <= RTR_IDLE;
            end
          end
          default: state_q[s] <= RTR_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge rst_ni) begin
    for (int s = 0; s < 2; s++) begin
      if (state_q[s] == RTR_IDLE && |want[s]) begin
        op_q[s]    <= m_op[win[s]];
        addr_q[s]  <= m_addr[win[s]];
        wdata_q[s] <= m_wdata[win[s]];
      end
      // Delayed along with ack
      rdata_q[s] <= s_rdata[s];
    end
  end

  assign s0_req_o   = req_q[0];
  assign s0_op_o    = op_q[0];
  assign s0_addr_o  = addr_q[0];
  assign s0_wdata_o = wdata_q[0];
  assign s1_req_o   = req_q[1];
  assign s1_op_o    = op_q[1];
  assign s1_addr_o  = addr_q[1];
  assign s1_wdata_o = wdata_q[1];

  // Return path to whichever master holds the grant
  assign m0_ack_o   = (ack_q[0] && !gnt_q[0]) || (ack_q[1] && !gnt_q[1]);
  assign m1_ack_o   = (ack_q[0] && gnt_q[0]) || (ack_q[1] && gnt_q[1]);
  assign m0_rdata_o = (ack_q[1] && !gnt_q[1]) ? rdata_q[1] : rdata_q[0];
  assign m1_rdata_o = (ack_q[1] && gnt_q[1]) ? rdata_q[1] : rdata_q[0];

endmodule

`default_nettype wire

// File: source/test_node.sv
// Test node
// Network endpoint acting as master through its traffic generator and
// as slave through its memory responder

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module test_node (
  input  logic                   rst_ni,      // Clock
  input  logic                   rst_n_i,     // Async reset, active low
  input  logic                   start_i,
  input  logic [`NOC_DATA_W-1:0] seed_i,
  input  logic [`NOC_CNT_W-1:0]  num_txn_i,
  input  logic                   node_id_i,
  output logic                   m_req_o,
  output noc_pkg::noc_op_e       m_op_o,
  output logic [`NOC_ADDR_W-1:0] m_addr_o,
  output logic [`NOC_DATA_W-1:0] m_wdata_o,
  input  logic                   m_ack_i,
  input  logic [`NOC_DATA_W-1:0] m_rdata_i,
  input  logic                   s_req_i,
  input  noc_pkg::noc_op_e       s_op_i,
  input  logic [`NOC_ADDR_W-1:0] s_addr_i,
  input  logic [`NOC_DATA_W-1:0] s_wdata_i,
  output logic                   s_ack_o,
  output logic [`NOC_DATA_W-1:0] s_rdata_o,
  output logic                   done_o,
  output logic [`NOC_CNT_W-1:0]  err_count_o
);

  traffic_gen u_gen (
    .rst_ni      (rst_ni),
    .rst_n_i     (rst_n_i),
    .start_i     (start_i),
    .seed_i      (seed_i),
    .num_txn_i   (num_txn_i),
    .node_id_i   (node_id_i),
    .req_o       (m_req_o),
    .op_o        (m_op_o),
    .addr_o      (m_addr_o),
    .wdata_o     (m_wdata_o),
    .ack_i       (m_ack_i),
    .rdata_i     (m_rdata_i),
    .done_o      (done_o),
    .err_count_o (err_count_o)
  );

  mem_responder u_mem (
    .rst_ni  (rst_ni),
    .rst_n_i (rst_n_i),
    .req_i   (s_req_i),
    .op_i    (s_op_i),
    .addr_i  (s_addr_i),
    .wdata_i (s_wdata_i),
    .ack_o   (s_ack_o),
    .rdata_o (s_rdata_o)
  );

endmodule

`default_nettype wire

// File: source/traffic_gen.sv
// Traffic generator
// Issues LFSR-driven writes, then replays the same addresses as reads
// and compares each read word against a shadow of its own writes

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module traffic_gen (
  input  logic                   rst_ni,      // Clock
  input  logic                   rst_n_i,     // Async reset, active low
  input  logic                   start_i,
  input  logic [`NOC_DATA_W-1:0] seed_i,
  input  logic [`NOC_CNT_W-1:0]  num_txn_i,
  input  logic                   node_id_i,
  output logic                   req_o,
  output noc_pkg::noc_op_e       op_o,
  output logic [`NOC_ADDR_W-1:0] addr_o,
  output logic [`NOC_DATA_W-1:0] wdata_o,
  input  logic                   ack_i,
  input  logic [`NOC_DATA_W-1:0] rdata_i,
  output logic                   done_o,
  output logic [`NOC_CNT_W-1:0]  err_count_o
);

  import noc_pkg::*;

  localparam int IDX_W = $clog2(`NOC_MEM_DEPTH);

  gen_state_e             state_q;
  noc_op_e                op_q;
  logic [`NOC_DATA_W-1:0] lfsr_q;
  logic [`NOC_DATA_W-1:0] seed_q;
  logic [`NOC_CNT_W-1:0]  cnt_q;
  logic [`NOC_CNT_W-1:0]  num_q;
  logic [`NOC_CNT_W-1:0]  err_q;
  logic                   last_txn;

  // Last word written to each of this node's addresses
  logic [`NOC_DATA_W-1:0] shadow [`NOC_MEM_DEPTH];
  logic [IDX_W-1:0]       sh_idx;

  // One Galois step, shift right and fold in the taps
  function automatic logic [`NOC_DATA_W-1:0] lfsr_step(input logic [`NOC_DATA_W-1:0] v);
    lfsr_step = (v >> 1) ^ (v[0] ? `NOC_LFSR_POLY : '0);
  endfunction

  // Target bit and word index, the owner bit is constant per node
  assign sh_idx   = {lfsr_q[`NOC_DATA_W-1], lfsr_q[IDX_W-2:0]};
  assign last_txn = (cnt_q + 1'b1) == num_q;

  always_ff @(posedge rst_ni or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= GEN_IDLE;
      op_q    <= OP_WRITE;
      lfsr_q  <= '0;
      seed_q  <= '0;
      cnt_q   <= '0;
      num_q   <= '0;
      err_q   <= '0;
    end else begin
      case (state_q)
        GEN_IDLE, GEN_DONE: begin
          if (start_i) begin
            lfsr_q <= seed_i;
            seed_q <= seed_i;
            num_q  <= num_txn_i;
            cnt_q  <= '0;
            err_q  <= '0;
            op_q   <= OP_WRITE;
            if (num_txn_i == '0) begin
              state_q <= GEN_DONE;
            end else begin
              state_q <= GEN_REQ;
            end
          end
        end
        GEN_REQ: begin
          if (ack_i) begin
            if (op_q == OP_READ && rdata_i != shadow[sh_idx]) begin
              err_q <= err_q + 1'b1;
            end
            state_q <= GEN_WAIT_ACK_LOW;
          end
        end
        GEN_WAIT_ACK_LOW: begin
          if (!ack_i) begin
            state_q <= GEN_NEXT;
          end
        end
        GEN_NEXT: begin
          cnt_q   <= cnt_q + 1'b1;
          lfsr_q  <= lfsr_step(lfsr_q);
          state_q <= GEN_REQ;
          if (last_txn) begin
            cnt_q <= '0;
            if (op_q == OP_WRITE) begin
              // Replay the write sequence as reads
              op_q   <= OP_READ;
              lfsr_q <= seed_q;
            end else begin
              state_q <= GEN_DONE;
            end
          end
        end
        default: state_q <= GEN_IDLE;
      endcase
    end
  end

  always_ff @(posedge rst_ni) begin
    if (state_q == GEN_REQ && ack_i && op_q == OP_WRITE) begin
      shadow[sh_idx] <= lfsr_q;
    end
  end

  assign req_o       = (state_q == GEN_REQ);
  assign op_o        = op_q;
  assign addr_o      = {lfsr_q[`NOC_DATA_W-1], node_id_i, lfsr_q[`NOC_ADDR_W-3:0]};
  assign wdata_o     = lfsr_q;
  assign done_o      = (state_q == GEN_DONE);
  assign err_count_o = err_q;

endmodule

`default_nettype wire

// File: testbench/noc_stimulus.txt
# One test run per line, all fields in hex
# seed0 seed1 num_txn expected_monitor_count
ACE1 ACE1 10 40
1234 8001 08 20
FFFF FFFF 30 C0
0001 5A5A 05 14
BEEF BEEF 40 100
C3A5 0F0F 20 80

// File: testbench/noc_test_properties.sv
// Router handshake properties
// Four-phase rules on the master ports and on the slave ack returns

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module noc_test_properties (
  input logic                                 rst_ni,   // Clock
  input logic                                 rst_n_i,  // Async reset, active low
  input logic                                 m0_req_i,
  input logic                                 m0_ack_i,
  input logic [`NOC_ADDR_W+`NOC_DATA_W:0]     m0_fields_i,
  input logic                                 m1_req_i,
  input logic                                 m1_ack_i,
  input logic [`NOC_ADDR_W+`NOC_DATA_W:0]     m1_fields_i,
  input logic                                 s0_req_i,
  input logic                                 s0_ack_i,
  input logic                                 s1_req_i,
  input logic                                 s1_ack_i
);

  // Ack only answers a live request
  m0_ack_req: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(m0_ack_i) |-> m0_req_i) else $error("m0 ack rose with req low");
  m1_ack_req: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(m1_ack_i) |-> m1_req_i) else $error("m1 ack rose with req low");
  s0_ack_req: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(s0_ack_i) |-> s0_req_i) else $error("s0 ack rose with req low");
  s1_ack_req: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(s1_ack_i) |-> s1_req_i) else $error("s1 ack rose with req low");

  // Op, address and write data from each generator hold for the whole request
  m0_stable: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    m0_req_i && $past(m0_req_i) |-> $stable(m0_fields_i)) else $error("m0 fields moved");
  m1_stable: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    m1_req_i && $past(m1_req_i) |-> $stable(m1_fields_i)) else $error("m1 fields moved");

  // Next generator request only after the previous ack has fallen
  m0_new_req: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(m0_req_i) |-> !m0_ack_i) else $error("m0 req rose with ack high");
  m1_new_req: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $rose(m1_req_i) |-> !m1_ack_i) else $error("m1 req rose with ack high");

endmodule

`default_nettype wire

// File: testbench/noc_test_tb.sv
// NoC test system testbench
// Runs each stimulus line through both nodes and checks the monitor
// stream against an LFSR reference model and a word memory model

`timescale 1ns/100ps
`default_nettype none
`include "noc_defines.svh"

module noc_test_tb;

  import noc_pkg::*;

  localparam int    TIMEOUT_CYCLES = 20000;
  localparam string STIM_FILE      = "testbench/noc_stimulus.txt";

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  logic [`NOC_DATA_W-1:0] seed0;
  logic [`NOC_DATA_W-1:0] seed1;
  logic [`NOC_CNT_W-1:0]  num_txn;
  logic [1:0]             done;
  logic [`NOC_CNT_W-1:0]  err_count0;
  logic [`NOC_CNT_W-1:0]  err_count1;
  logic                   mon_valid;
  logic                   mon_node;
  noc_op_e                mon_op;
  logic [`NOC_ADDR_W-1:0] mon_addr;
  logic [`NOC_DATA_W-1:0] mon_data;

  // Predicted write sequence per issuing node, reads replay the addresses
  logic [`NOC_ADDR_W-1:0] pred_addr [2][1 << `NOC_CNT_W];
  logic [`NOC_DATA_W-1:0] pred_data [2][1 << `NOC_CNT_W];
  logic [`NOC_DATA_W-1:0] model_mem [1 << `NOC_ADDR_W];
  int                     wr_seen [2];
  int                     rd_seen [2];
  int                     run_txn;
  int                     mon_total;

  noc_test_top u_noc_test_top (
    .rst_ni       (clk),
    .rst_n_i      (rst_n),
    .start_i      (start),
    .seed0_i      (seed0),
    .seed1_i      (seed1),
    .num_txn_i    (num_txn),
    .done_o       (done),
    .err_count0_o (err_count0),
    .err_count1_o (err_count1),
    .mon_valid_o  (mon_valid),
    .mon_node_o   (mon_node),
    .mon_op_o     (mon_op),
    .mon_addr_o   (mon_addr),
    .mon_data_o   (mon_data)
  );

  bind req_router noc_test_properties u_props (
    .rst_ni      (rst_ni),
    .rst_n_i     (rst_n_i),
    .m0_req_i    (m0_req_i),
    .m0_ack_i    (m0_ack_o),
    .m0_fields_i ({m0_op_i, m0_addr_i, m0_wdata_i}),
    .m1_req_i    (m1_req_i),
    .m1_ack_i    (m1_ack_o),
    .m1_fields_i ({m1_op_i, m1_addr_i, m1_wdata_i}),
    .s0_req_i    (s0_req_o),
    .s0_ack_i    (s0_ack_i),
    .s1_req_i    (s1_req_o),
    .s1_ack_i    (s1_ack_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic report_failure();
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Galois step shifting right and folding in the taps
  function automatic logic [`NOC_DATA_W-1:0] lfsr_next(input logic [`NOC_DATA_W-1:0] v);
    logic [`NOC_DATA_W-1:0] r;
    r = {1'b0, v[`NOC_DATA_W-1:1]};
    if (v[0]) begin
      r = r ^ `NOC_LFSR_POLY;
    end
    return r;
  endfunction

  task automatic predict_node(input logic node, input logic [`NOC_DATA_W-1:0] seed,
                              input int count);
    logic [`NOC_DATA_W-1:0] v;
    v = seed;
    for (int k = 0; k < count; k++) begin
      // Target from the top bit, owner is the issuing node
      pred_addr[node][k] = {v[`NOC_DATA_W-1], node, v[`NOC_ADDR_W-3:0]};
      pred_data[node][k] = v;
      v = lfsr_next(v);
    end
  endtask

  task automatic check_transaction();
    logic owner;
    int   k;
    owner = mon_addr[`NOC_ADDR_W-2];
    mon_total++;
    assert (mon_node == mon_addr[`NOC_ADDR_W-1]) else begin
      $display("MISMATCH mon_node_o: got %h, expected %h", mon_node, mon_addr[`NOC_ADDR_W-1]);
      report_failure();
    end
    if (mon_op == OP_WRITE) begin
      k = wr_seen[owner];
      assert (k < run_txn) else begin
        $display("Node %0d issued more writes than requested", owner);
        report_failure();
      end
      assert (mon_addr == pred_addr[owner][k]) else begin
        $display("MISMATCH mon_addr_o: got %h, expected %h", mon_addr, pred_addr[owner][k]);
        report_failure();
      end
      assert (mon_data == pred_data[owner][k]) else begin
        $display("MISMATCH mon_data_o: got %h, expected %h", mon_data, pred_data[owner][k]);
        report_failure();
      end
      model_mem[mon_addr] = mon_data;
      wr_seen[owner] = k + 1;
    end else begin
      k = rd_seen[owner];
      assert (wr_seen[owner] == run_txn && k < run_txn) else begin
        $display("Node %0d read out of sequence", owner);
        report_failure();
      end
      assert (mon_addr == pred_addr[owner][k]) else begin
        $display("MISMATCH mon_addr_o: got %h, expected %h", mon_addr, pred_addr[owner][k]);
        report_failure();
      end
      assert (mon_data == model_mem[mon_addr]) else begin
        $display("MISMATCH mon_data_o: got %h, expected %h", mon_data, model_mem[mon_addr]);
        report_failure();
      end
      rd_seen[owner] = k + 1;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && mon_valid) begin
      check_transaction();
    end
  end

  task automatic run_test(input logic [`NOC_DATA_W-1:0] s0, input logic [`NOC_DATA_W-1:0] s1,
                          input int n, input int exp_total);
    int cycles;
    assert (n > 0 && n < (1 << `NOC_CNT_W) && exp_total == 4 * n) else begin
      $display("Stimulus line has a bad count %0d or total %0d", n, exp_total);
      report_failure();
    end
    predict_node(1'b0, s0, n);
    predict_node(1'b1, s1, n);
    wr_seen   = '{0, 0};
    rd_seen   = '{0, 0};
    run_txn   = n;
    mon_total = 0;
    @(posedge clk);
    seed0   <= s0;
    seed1   <= s1;
    num_txn <= n[`NOC_CNT_W-1:0];
    start   <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (done != 2'b11 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    assert (done == 2'b11) else begin
      $display("Timeout after %0d cycles waiting for both done_o bits", cycles);
      report_failure();
    end
    assert (err_count0 == '0) else begin
      $display("MISMATCH err_count0_o: got %h, expected 00", err_count0);
      report_failure();
    end
    assert (err_count1 == '0) else begin
      $display("MISMATCH err_count1_o: got %h, expected 00", err_count1);
      report_failure();
    end
    // Monitor counters only move on falling edges
    @(posedge clk);
    assert (mon_total == exp_total) else begin
      $display("MISMATCH monitor count: got %h, expected %h", mon_total, exp_total);
      report_failure();
    end
    assert (rd_seen[0] == n && rd_seen[1] == n) else begin
      $display("A node finished without reading back every address");
      report_failure();
    end
  endtask

  initial begin
    int                     fd;
    int                     code;
    int                     n;
    int                     exp_total;
    int                     runs;
    string                  line;
    logic [`NOC_DATA_W-1:0] s0;
    logic [`NOC_DATA_W-1:0] s1;
    rst_n   = 1'b0;
    start   = 1'b0;
    seed0   = '0;
    seed1   = '0;
    num_txn = '0;
    runs    = 0;
    run_txn = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (done == 2'b00 && !mon_valid) else begin
      $display("Outputs not idle after reset");
      report_failure();
    end
    fd = $fopen(STIM_FILE, "r");
    assert (fd != 0) else begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      report_failure();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%h %h %h %h", s0, s1, n, exp_total);
        assert (code == 4) else begin
          $display("Malformed stimulus line: %s", line);
          report_failure();
        end
        run_test(s0, s1, n, exp_total);
        runs++;
      end
    end
    $fclose(fd);
    assert (runs > 0) else begin
      $display("Stimulus file holds no test run");
      report_failure();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
source/noc_pkg.sv
source/traffic_gen.sv
source/mem_responder.sv
source/req_router.sv
source/test_node.sv
source/noc_test_top.sv
testbench/noc_test_properties.sv
testbench/noc_test_tb.sv
